//--- source/cachePkg.sv
package cachePkg;

	////////////////////////////////////////
	// bus and cache geometry
	////////////////////////////////////////

	typedef logic [15:0] wordT;          // one word on the 16 bit data bus
	typedef logic [31:0] addressT;       // byte address from the processor
	typedef logic [24:0] tagT;           // address bits 31 to 7
	typedef logic [2:0]  indexT;         // address bits 6 to 4 select the line
	typedef logic [2:0]  wordSelT;       // address bits 3 to 1 select the word
	typedef logic [1:0]  wayT;           // one of the four ways
	typedef logic [3:0]  wayMaskT;       // one bit per way
	typedef logic [2:0]  plruT;          // tree bits of one line

	localparam int LineCount  = 8;       // lines in every way
	localparam int LineWords  = 8;       // words in every line
	localparam int WayCount   = 4;
	localparam int WordLsb    = 1;       // bit 0 picks the byte, so words start at bit 1
	localparam int IndexLsb   = 4;
	localparam int TagLsb     = 7;
	localparam int OffsetBits = 4;       // byte offset inside a line, zeroed on line reads

	// the sequencer walks these states, the sweep runs once after every reset
	typedef enum logic [3:0] {
		ResetSweepStart,
		InvalidateSweep,
		Idle,
		CheckHit,
		HitRead,
		AwaitReadCommand,
		CasWait,
		BurstFill,
		FillDone,
		WriteThrough
	} seqStateT;

	// what the processor drives toward the cache
	typedef struct packed {
		addressT address;
		wordT    writeData;
		logic    uds_L;                  // upper byte strobe
		logic    lds_L;                  // lower byte strobe
		logic    we_L;                   // low for a write
		logic    as_L;                   // held low for the whole bus cycle
		logic    dramSelect;             // high when the address decodes to DRAM
	} cpuRequestT;

	// what the cache drives toward the DRAM controller
	typedef struct packed {
		addressT address;
		wordT    writeData;
		logic    uds_L;
		logic    lds_L;
		logic    we_L;
		logic    as_L;
		logic    select_L;               // starts a DRAM access when low
	} dramRequestT;

	// what the DRAM controller hands back
	typedef struct packed {
		logic cas_L;                     // low with ras_L high is a read command
		logic ras_L;                     // low together with cas_L means refresh
		logic dtack_L;                   // ends a write
		wordT readData;                  // burst words during a fill
	} dramStatusT;

endpackage

//--- source/sweepCounter.sv
`timescale 1ns/1ps

module sweepCounter (
	input  logic              Clock,
	input  logic              counterClear,    // synchronous, wins over counting
	output cachePkg::wordSelT count,
	output logic              countDone
);
	import cachePkg::*;

	logic [3:0] value;                         // one spare bit so the done flag fires once per clear

	// counts one per clock from the clear, shared by the sweep, the CAS wait and the fill
	always_ff @(posedge Clock) begin
		if (counterClear) begin
			value <= '0;
		end else begin
			value <= value + 4'd1;
		end
	end

	assign count = value[2:0];                 // line number in the sweep, word number in a fill

	// high in the eighth cycle after a clear, so the last line or word is being handled
	assign countDone = (value == 4'(LineWords - 1));

endmodule

//--- source/plruStore.sv
`timescale 1ns/1ps

module plruStore (
	input  logic            Clock,
	input  logic            Reset_L,
	input  cachePkg::indexT index,
	input  logic            plruWrite,    // update the indexed entry on the next edge
	input  logic            plruClear,    // during the sweep the entry goes to zero instead
	input  cachePkg::wayT   touchWay,
	output cachePkg::wayT   victimWay
);
	import cachePkg::*;

	plruT plruArray [LineCount];          // three tree bits per line
	plruT current;                        // entry of the line being addressed
	plruT touched;                        // entry after marking touchWay as recently used

	assign current = plruArray[index];

	// bit 0 picks the half, then bit 1 or bit 2 picks the way inside that half
	assign victimWay = {current[0], (current[0] ? current[2] : current[1])};

	////////////////////////////////////////
	// touch rule
	////////////////////////////////////////

	// point the tree away from the touched way, the bit of the other half is kept
	always_comb begin
		touched    = current;
		touched[0] = ~touchWay[1];          // next victim comes from the other half
		if (touchWay[1]) begin
			touched[2] = ~touchWay[0];        // inside ways 2 and 3 point at the sibling
		end else begin
			touched[1] = ~touchWay[0];        // inside ways 0 and 1 point at the sibling
		end
	end

	// every line starts from way 0 after reset, and the sweep clears it once more
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			for (int line = 0; line < LineCount; line++) begin
				plruArray[line] <= '0;
			end
		end else if (plruWrite) begin
			if (plruClear) begin
				plruArray[index] <= '0;
			end else begin
				plruArray[index] <= touched;
			end
		end
	end

endmodule

//--- source/tagStore.sv
`timescale 1ns/1ps

module tagStore (
	input  logic              Clock,
	input  cachePkg::indexT   index,
	input  cachePkg::tagT     tag,          // tag to compare and, when enabled, to store
	input  cachePkg::wayMaskT tagWrite,     // one enable per way
	input  cachePkg::wayMaskT validWrite,   // one enable per way
	input  logic              validValue,   // value written into the enabled valid bits
	output cachePkg::wayMaskT hitMask
);
	import cachePkg::*;

	////////////////////////////////////////
	// arrays
	////////////////////////////////////////

	tagT  tagArray   [WayCount][LineCount];
	logic validArray [WayCount][LineCount];

	// tag and valid bits are written separately, so a write can drop a line
	// without touching its tag
	always_ff @(posedge Clock) begin
		for (int way = 0; way < WayCount; way++) begin
			if (tagWrite[way]) begin
				tagArray[way][index] <= tag;
			end
			if (validWrite[way]) begin
				validArray[way][index] <= validValue;
			end
		end
	end

	////////////////////////////////////////
	// compare
	////////////////////////////////////////

	// all four ways are looked at in the same cycle, at most one of them can hit
	// because a line is only filled after a miss
	always_comb begin
		for (int way = 0; way < WayCount; way++) begin
			hitMask[way] = validArray[way][index] && (tagArray[way][index] == tag);
		end
	end

endmodule

//--- source/lineStore.sv
`timescale 1ns/1ps

module lineStore (
	input  logic              Clock,
	input  cachePkg::indexT   index,
	input  cachePkg::wordSelT wordSelect,
	input  cachePkg::wayMaskT dataWrite,    // the victim way during a burst fill
	input  cachePkg::wayMaskT hitMask,      // steers the read mux
	input  cachePkg::wordT    writeData,    // burst word from DRAM
	output cachePkg::wordT    readData
);
	import cachePkg::*;

	wordT dataArray [WayCount][LineCount][LineWords];

	// one word per clock during a fill, the processor never writes here
	always_ff @(posedge Clock) begin
		for (int way = 0; way < WayCount; way++) begin
			if (dataWrite[way]) begin
				dataArray[way][index][wordSelect] <= writeData;
			end
		end
	end

	// the word of the hitting way, zero when no way hits
	always_comb begin
		readData = '0;
		for (int way = 0; way < WayCount; way++) begin
			if (hitMask[way]) begin
				readData = dataArray[way][index][wordSelect];
			end
		end
	end

endmodule

//--- source/cacheSequencer.sv
`timescale 1ns/1ps

module cacheSequencer #(
	parameter int CasLatency = 2                // clocks from read command to first word
) (
	input  logic                 Clock,
	input  logic                 Reset_L,
	input  cachePkg::cpuRequestT cpuRequest,
	input  cachePkg::dramStatusT dramStatus,
	input  cachePkg::wayMaskT    hitMask,
	input  cachePkg::wayT        victimWay,     // straight from the PLRU store
	input  cachePkg::wordSelT    count,
	input  logic                 countDone,
	output logic                 counterClear,
	output logic                 sweepActive,   // index comes from the counter
	output cachePkg::wayMaskT    tagWrite,
	output cachePkg::wayMaskT    validWrite,
	output cachePkg::wayMaskT    dataWrite,
	output logic                 validValue,
	output cachePkg::wordSelT    wordSelect,
	output logic                 plruWrite,
	output logic                 plruClear,
	output cachePkg::wayT        touchWay,
	output logic                 dtack_L,       // to the processor
	output logic                 select_L,      // to the DRAM controller
	output logic                 forceBothStrobes
);
	import cachePkg::*;

	localparam wordSelT CasLast = wordSelT'(CasLatency - 1);   // last count of the CAS wait

	seqStateT state;
	seqStateT nextState;
	wayT      victimLatched;                    // way chosen in CheckHit, kept for the fill
	logic     latchVictim;
	wayT      hitWay;
	wayMaskT  victimMask;

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state         <= ResetSweepStart;
			victimLatched <= '0;
		end else begin
			state <= nextState;
			if (latchVictim) begin
				victimLatched <= victimWay;
			end
		end
	end

	// encode the hit mask, the tag store never reports two ways at once
	always_comb begin
		hitWay = '0;
		for (int way = WayCount - 1; way >= 0; way--) begin
			if (hitMask[way]) begin
				hitWay = wayT'(way);
			end
		end
	end

	always_comb begin
		victimMask                = '0;
		victimMask[victimLatched] = 1'b1;
	end

	////////////////////////////////////////
	// next state and outputs
	////////////////////////////////////////

	always_comb begin
		nextState        = state;
		counterClear     = 1'b0;
		sweepActive      = 1'b0;
		tagWrite         = '0;
		validWrite       = '0;
		dataWrite        = '0;
		validValue       = 1'b0;
		wordSelect       = cpuRequest.address[WordLsb +: $bits(wordSelT)];  // requested word
		plruWrite        = 1'b0;
		plruClear        = 1'b0;
		touchWay         = victimWay;
		dtack_L          = 1'b1;
		select_L         = 1'b1;
		forceBothStrobes = 1'b0;
		latchVictim      = 1'b0;

		unique case (state)
			ResetSweepStart: begin
				counterClear = 1'b1;                 // sweep starts at line 0
				nextState    = InvalidateSweep;
			end
			InvalidateSweep: begin
				sweepActive = 1'b1;                  // one line per clock, all ways at once
				tagWrite    = '1;
				validWrite  = '1;
				plruWrite   = 1'b1;
				plruClear   = 1'b1;
				if (countDone) begin
					nextState = Idle;
				end
			end
			Idle: begin
				if (!cpuRequest.as_L && cpuRequest.dramSelect) begin
					if (cpuRequest.we_L) begin
						forceBothStrobes = 1'b1;          // a line always holds whole words
						nextState        = CheckHit;
					end else begin
						select_L   = 1'b0;                // write goes straight to DRAM
						validWrite = hitMask;             // and drops any copy we hold
						nextState  = WriteThrough;
					end
				end
			end
			CheckHit: begin
				forceBothStrobes = 1'b1;
				plruWrite        = 1'b1;
				if (|hitMask) begin
					dtack_L   = 1'b0;
					touchWay  = hitWay;                 // the hit way becomes most recent
					nextState = HitRead;
				end else begin
					select_L    = 1'b0;                 // start the line read right away
					latchVictim = 1'b1;                 // the victim is touched as well
					nextState   = AwaitReadCommand;
				end
			end
			HitRead: begin
				forceBothStrobes = 1'b1;
				dtack_L          = 1'b0;              // word and dtack hold until the cycle ends
				if (cpuRequest.as_L) begin
					nextState = Idle;
				end
			end
			AwaitReadCommand: begin
				forceBothStrobes = 1'b1;
				select_L         = 1'b0;
				tagWrite         = victimMask;        // claim the victim way for the new tag
				validWrite       = victimMask;
				validValue       = 1'b1;
				// refresh has both strobes low and is let go by
				if (!dramStatus.cas_L && dramStatus.ras_L) begin
					counterClear = 1'b1;
					nextState    = CasWait;
				end
			end
			CasWait: begin
				forceBothStrobes = 1'b1;
				select_L         = 1'b0;
				if (count == CasLast) begin
					counterClear = 1'b1;               // first word arrives next clock
					nextState    = BurstFill;
				end
			end
			BurstFill: begin
				forceBothStrobes = 1'b1;
				select_L         = 1'b0;
				wordSelect       = count;             // DRAM streams the words in order
				dataWrite        = victimMask;
				if (countDone) begin
					nextState = FillDone;
				end
			end
			FillDone: begin
				forceBothStrobes = 1'b1;
				dtack_L          = 1'b0;              // the filled way now hits, answer from it
				if (cpuRequest.as_L || !cpuRequest.dramSelect) begin
					nextState = Idle;
				end
			end
			WriteThrough: begin
				select_L = 1'b0;
				dtack_L  = dramStatus.dtack_L;       // the controller decides when the write ends
				if (cpuRequest.as_L || !cpuRequest.dramSelect) begin
					nextState = Idle;
				end
			end
			default: begin
				nextState = ResetSweepStart;
			end
		endcase
	end

endmodule

//--- source/cacheController.sv
`timescale 1ns/1ps

module cacheController #(
	parameter int CasLatency = 2
) (
	input  logic                  Clock,
	input  logic                  Reset_L,
	input  cachePkg::cpuRequestT  cpuRequest,
	output cachePkg::wordT        readData,     // to the processor
	output logic                  dtack_L,
	output cachePkg::dramRequestT dramRequest,
	input  cachePkg::dramStatusT  dramStatus
);
	import cachePkg::*;

	tagT     addressTag;
	tagT     storeTag;                          // zero while the sweep clears the tags
	indexT   index;
	wordSelT count;
	logic    countDone;
	logic    counterClear;
	logic    sweepActive;
	wayMaskT tagWrite;
	wayMaskT validWrite;
	wayMaskT dataWrite;
	logic    validValue;
	wordSelT wordSelect;
	logic    plruWrite;
	logic    plruClear;
	wayT     touchWay;
	wayT     victimWay;
	wayMaskT hitMask;
	logic    select_L;
	logic    forceBothStrobes;

	////////////////////////////////////////
	// address split
	////////////////////////////////////////

	assign addressTag = cpuRequest.address[TagLsb +: $bits(tagT)];
	assign storeTag   = sweepActive ? '0 : addressTag;
	assign index      = sweepActive ? indexT'(count)
	                                : cpuRequest.address[IndexLsb +: $bits(indexT)];

	// reads fetch a whole line, so the offset and both strobes are forced, writes pass as is
	always_comb begin
		dramRequest.address   = cpuRequest.address;
		dramRequest.writeData = cpuRequest.writeData;
		dramRequest.uds_L     = cpuRequest.uds_L && !forceBothStrobes;
		dramRequest.lds_L     = cpuRequest.lds_L && !forceBothStrobes;
		dramRequest.we_L      = cpuRequest.we_L;
		dramRequest.as_L      = cpuRequest.as_L;
		dramRequest.select_L  = select_L;
		if (forceBothStrobes) begin
			dramRequest.address[OffsetBits-1:0] = '0;
		end
	end

	cacheSequencer #(.CasLatency(CasLatency)) i_sequencer (
		.Clock, .Reset_L, .cpuRequest, .dramStatus, .hitMask, .victimWay, .count, .countDone,
		.counterClear, .sweepActive, .tagWrite, .validWrite, .dataWrite, .validValue,
		.wordSelect, .plruWrite, .plruClear, .touchWay, .dtack_L, .select_L, .forceBothStrobes
	);

	sweepCounter i_counter (.Clock, .counterClear, .count, .countDone);

	plruStore i_plru (
		.Clock, .Reset_L, .index, .plruWrite, .plruClear, .touchWay, .victimWay
	);

	tagStore i_tags (
		.Clock, .index, .tag(storeTag), .tagWrite, .validWrite, .validValue, .hitMask
	);

	lineStore i_lines (
		.Clock, .index, .wordSelect, .dataWrite, .hitMask,
		.writeData(dramStatus.readData), .readData
	);

endmodule

//--- test/cacheController_properties.sv
`timescale 1ns/1ps

module cacheControllerProperties (
	input logic                  Clock,
	input logic                  Reset_L,
	input cachePkg::cpuRequestT  cpuRequest,
	input logic                  dtack_L,
	input cachePkg::dramRequestT dramRequest
);
	int failCount = 0;                 // number of failed assertions in this run

	// the processor must never see an acknowledge while the cache is held in reset
	assert property (@(posedge Clock) !Reset_L |-> dtack_L)
	else begin
		failCount++;
		$error("dtack_L is low while Reset_L is low");
	end

	// a line read owns the DRAM until FillDone, and FillDone releases select_L first
	assert property (@(posedge Clock) disable iff (!Reset_L)
		(!dramRequest.select_L && dramRequest.we_L && !dramRequest.as_L) |-> dtack_L)
	else begin
		failCount++;
		$error("select_L and dtack_L are both low during a line read");
	end

	// the end of a bus cycle must release dtack_L by the next clock
	assert property (@(posedge Clock) disable iff (!Reset_L)
		$rose(cpuRequest.as_L) |=> dtack_L)
	else begin
		failCount++;
		$error("dtack_L still low one cycle after as_L rose");
	end

endmodule

//--- test/cacheChecker.sv
`timescale 1ns/1ps

module cacheChecker #(
	parameter int CasLatency = 2
) (
	input  logic                  Clock,
	input  logic                  Reset_L,
	input  cachePkg::cpuRequestT  cpuRequest,
	input  cachePkg::wordT        readData,
	input  logic                  dtack_L,
	input  cachePkg::dramRequestT dramRequest,
	input  cachePkg::dramStatusT  dramStatus,
	input  logic                  reportNow,     // print the closing line once the bus is quiet
	output logic                  reported,
	output int                    errorCount
);
	import cachePkg::*;

	localparam int StepLimit = 200;             // cycles allowed for one phase of a bus cycle

	// the test tags differ in address bits 8 and 7, so bits 8 to 1 name every word used
	wordT       memory  [256];
	logic       written [256];
	tagT        modelTag   [4][8];
	logic       modelValid [4][8];
	plruT       modelPlru  [8];
	cpuRequestT request;                         // the bus cycle being watched
	int         phase;                           // 0 waits for as_L, 1 waits for dtack_L, 2 for the end
	int         steps;
	int         cycle;
	int         cmdCycle;                        // cycle of the last DRAM read command
	logic       selectSeen;
	int         reads;
	int         writes;
	int         hits;
	int         misses;

	////////////////////////////////////////
	// reference rules
	////////////////////////////////////////

	function automatic wordT referenceWord(input addressT address);
		if (written[address[8:1]]) begin
			return memory[address[8:1]];
		end
		return address[31:16] ^ address[15:0] ^ 16'h6C1D;   // untouched DRAM content
	endfunction

	// a clear bit 0 sends the victim to ways 0 and 1, where bit 1 decides
	function automatic wayT victimOf(input plruT bits);
		if (!bits[0]) begin
			return bits[1] ? 2'd1 : 2'd0;
		end
		return bits[2] ? 2'd3 : 2'd2;              // otherwise bit 2 decides between 2 and 3
	endfunction

	function automatic plruT touchedPlru(input plruT bits, input wayT way);
		plruT result;
		result = bits;
		case (way)
			2'd0: begin
				result[0] = 1'b1;
				result[1] = 1'b1;
			end
			2'd1: begin
				result[0] = 1'b1;
				result[1] = 1'b0;
			end
			2'd2: begin
				result[0] = 1'b0;
				result[2] = 1'b1;
			end
			default: begin
				result[0] = 1'b0;
				result[2] = 1'b0;
			end
		endcase
		return result;
	endfunction

	task automatic reportValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERR %s expected %h got %h", name, expected, actual);
		errorCount++;
	endtask

	task automatic reportProblem(input string text);
		$display("problem: %s", text);
		errorCount++;
	endtask

	// the first DRAM select of a cycle shows what the cache asks of the controller
	task automatic checkDramRequest();
		if (dramRequest.as_L !== 1'b0)
			reportValue("dramRequest.as_L", 1'b0, dramRequest.as_L);
		if (request.we_L) begin
			if (dramRequest.address !== {request.address[31:4], 4'h0})
				reportValue("dramRequest.address", {request.address[31:4], 4'h0},
					dramRequest.address);
			if ({dramRequest.uds_L, dramRequest.lds_L} !== 2'b00)
				reportValue("dramRequest.strobes", 2'b00, {dramRequest.uds_L, dramRequest.lds_L});
			if (dramRequest.we_L !== 1'b1)
				reportValue("dramRequest.we_L", 1'b1, dramRequest.we_L);
		end else begin
			if (dramRequest.address !== request.address)
				reportValue("dramRequest.address", request.address, dramRequest.address);
			if (dramRequest.writeData !== request.writeData)
				reportValue("dramRequest.writeData", request.writeData, dramRequest.writeData);
			if ({dramRequest.uds_L, dramRequest.lds_L} !== {request.uds_L, request.lds_L})
				reportValue("dramRequest.strobes", {request.uds_L, request.lds_L},
					{dramRequest.uds_L, dramRequest.lds_L});
			if (dramRequest.we_L !== 1'b0)
				reportValue("dramRequest.we_L", 1'b0, dramRequest.we_L);
		end
	endtask

	////////////////////////////////////////
	// end of a bus cycle
	////////////////////////////////////////

	task automatic finishRead();
		tagT    tag;
		indexT  index;
		int     hitWay;
		wayT    victim;
		wordT   expected;
		tag      = request.address[31:7];
		index    = request.address[6:4];
		hitWay   = -1;
		expected = referenceWord(request.address);
		for (int way = 0; way < 4; way++) begin
			if (modelValid[way][index] && modelTag[way][index] == tag) hitWay = way;
		end
		reads++;
		if (readData !== expected) reportValue("readData", expected, readData);
		if (selectSeen == (hitWay >= 0))
			reportProblem($sformatf("hit or miss of the read at %h differs from the model",
				request.address));
		if (hitWay >= 0) begin
			hits++;
			if (steps != 2)
				reportProblem("a read hit was not answered in the cycle after the request");
			// the hit way becomes the most recent one
			modelPlru[index] = touchedPlru(modelPlru[index], wayT'(hitWay));
		end else begin
			misses++;
			if (cmdCycle < 0) begin
				reportProblem("a read miss ended without a DRAM read command");
			end else if (cycle - cmdCycle != CasLatency + 9) begin
				reportProblem("the fill did not end nine cycles after the CAS latency");
			end
			victim                   = victimOf(modelPlru[index]);
			modelTag[victim][index]   = tag;
			modelValid[victim][index] = 1'b1;
			modelPlru[index]          = touchedPlru(modelPlru[index], victim);
		end
		$display("read  %h %s data %h", request.address, (hitWay >= 0) ? "hit " : "miss",
			readData);
	endtask

	task automatic finishWrite();
		wordT merged;
		merged = referenceWord(request.address);
		writes++;
		if (!selectSeen) reportProblem("a write never selected the DRAM");
		if (!request.uds_L) merged[15:8] = request.writeData[15:8];
		if (!request.lds_L) merged[7:0]  = request.writeData[7:0];
		memory[request.address[8:1]]  = merged;
		written[request.address[8:1]] = 1'b1;
		for (int way = 0; way < 4; way++) begin         // a write drops any cached copy
			if (modelTag[way][request.address[6:4]] == request.address[31:7])
				modelValid[way][request.address[6:4]] = 1'b0;
		end
		$display("write %h data %h strobes %b", request.address, request.writeData,
			{request.uds_L, request.lds_L});
	endtask

	// samples at the falling edge, where every DUT output has settled
	always @(negedge Clock) begin
		cycle++;
		if (!Reset_L) begin
			phase = 0;
			errorCount = 0;
			reported = 1'b0;
			{reads, writes, hits, misses} = '0;
			for (int n = 0; n < 256; n++) written[n] = 1'b0;
			for (int line = 0; line < 8; line++) begin
				modelPlru[line] = '0;
				for (int way = 0; way < 4; way++) modelValid[way][line] = 1'b0;
			end
		end else begin
			if (phase == 0 && !cpuRequest.as_L && cpuRequest.dramSelect) begin
				request    = cpuRequest;
				selectSeen = 1'b0;
				cmdCycle   = -1;
				steps      = 0;
				phase      = 1;
			end else if (phase == 0 && reportNow && !reported) begin
				$display("reads %0d (hits %0d, misses %0d), writes %0d, errors %0d",
					reads, hits, misses, writes, errorCount);
				reported = 1'b1;
			end
			if (phase == 1) begin
				steps++;
				if (!dramRequest.select_L && !selectSeen) begin
					checkDramRequest();
					selectSeen = 1'b1;
				end
				if (!dramStatus.cas_L && dramStatus.ras_L) cmdCycle = cycle;
				if (!dtack_L) begin
					if (request.we_L) finishRead();
					else finishWrite();
					phase = 2;
					steps = 0;
				end else if (steps > StepLimit) begin
					reportProblem("the cache gave no dtack_L for a bus cycle");
					phase = 2;
					steps = 0;
				end
			end else if (phase == 2) begin
				steps++;
				if (cpuRequest.as_L) begin
					phase = 0;
				end else if (steps > StepLimit) begin
					reportProblem("the processor never ended its bus cycle");
					phase = 0;
				end
			end
		end
	end

endmodule

//--- test/cacheControllerTb.sv
`timescale 1ns/1ps

// DRAM controller with random latency and refresh cycles slipped in before read commands
module dramModel #(
	parameter int CasLatency = 2,
	parameter int Seed       = 88558
) (
	input  logic                  Clock,
	input  logic                  Reset_L,
	input  cachePkg::dramRequestT request,
	output cachePkg::dramStatusT  status
);
	import cachePkg::*;

	typedef enum int {Ready, ReadDelay, ReadCas, Burst, WaitRelease, WriteDelay, WriteAck} dramStateT;

	dramStateT   state;
	wordT        memory  [256];
	logic        written [256];
	addressT     lineAddress;
	int          delay;
	int          wordIndex;
	integer      seed = Seed;
	logic [31:0] randomValue;
	wordT        merged;

	function automatic wordT storedWord(input addressT address);
		if (written[address[8:1]]) return memory[address[8:1]];
		return address[31:16] ^ address[15:0] ^ 16'h6C1D;
	endfunction

	always @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state  <= Ready;
			status <= '{cas_L: 1'b1, ras_L: 1'b1, dtack_L: 1'b1, readData: '0};
			for (int n = 0; n < 256; n++) written[n] = 1'b0;
		end else begin
			randomValue = $random(seed);
			status.cas_L <= 1'b1;                     // commands last one cycle
			status.ras_L <= 1'b1;
			case (state)
				Ready: if (!request.select_L && !request.as_L) begin
					lineAddress <= request.address;
					delay       <= randomValue[2:0] % 5;
					state       <= request.we_L ? ReadDelay : WriteDelay;
				end
				ReadDelay: if (delay == 0) begin
					status.cas_L <= 1'b0;                 // read command
					delay        <= CasLatency;
					state        <= ReadCas;
				end else begin
					delay <= delay - 1;
					if (randomValue[4:3] == 2'd0) begin   // refresh, which must not start a fill
						status.cas_L <= 1'b0;
						status.ras_L <= 1'b0;
					end
				end
				ReadCas: if (delay == 0) begin
					status.readData <= storedWord(lineAddress);
					wordIndex       <= 1;
					state           <= Burst;
				end else begin
					delay <= delay - 1;
				end
				Burst: begin
					status.readData <= storedWord(lineAddress + addressT'(2 * wordIndex));
					wordIndex       <= wordIndex + 1;
					if (wordIndex == 7) state <= WaitRelease;
				end
				WaitRelease: if (request.select_L) state <= Ready;
				WriteDelay: if (delay == 0) begin
					merged = storedWord(request.address);
					if (!request.uds_L) merged[15:8] = request.writeData[15:8];
					if (!request.lds_L) merged[7:0]  = request.writeData[7:0];
					memory[request.address[8:1]]  = merged;
					written[request.address[8:1]] = 1'b1;
					status.dtack_L <= 1'b0;
					state          <= WriteAck;
				end else begin
					delay <= delay - 1;
				end
				default: if (request.as_L) begin
					status.dtack_L <= 1'b1;
					state          <= Ready;
				end
			endcase
		end
	end

endmodule

module cacheControllerTb;
	import cachePkg::*;

	localparam int CasLatency       = 2;
	localparam int TransactionCount = 300;
	localparam int WaitLimit        = 200;

	logic        Clock   = 1'b0;
	logic        Reset_L = 1'b0;
	cpuRequestT  cpuRequest;
	wordT        readData;
	logic        dtack_L;
	dramRequestT dramRequest;
	dramStatusT  dramStatus;
	logic        reportNow = 1'b0;
	logic        reported;
	int          errorCount;
	integer      seed = 88558;

	always #5 Clock = ~Clock;

	cacheController #(.CasLatency(CasLatency)) i_dut (
		.Clock, .Reset_L, .cpuRequest, .readData, .dtack_L, .dramRequest, .dramStatus
	);

	dramModel #(.CasLatency(CasLatency), .Seed(88558)) i_dram (
		.Clock, .Reset_L, .request(dramRequest), .status(dramStatus)
	);

	cacheChecker #(.CasLatency(CasLatency)) i_checker (
		.Clock, .Reset_L, .cpuRequest, .readData, .dtack_L, .dramRequest, .dramStatus,
		.reportNow, .reported, .errorCount
	);

	bind cacheController cacheControllerProperties i_properties (
		.Clock, .Reset_L, .cpuRequest, .dtack_L, .dramRequest
	);

	////////////////////////////////////////
	// processor side
	////////////////////////////////////////

	// three tags with distinct low bits, so every test word has its own slot in the models
	function automatic tagT pickTag(input logic [1:0] choice);
		case (choice)
			2'd0:    return 25'h1234560;
			2'd1:    return 25'h0ABCDE1;
			default: return 25'h1F00F02;
		endcase
	endfunction

	task automatic waitForAck(output logic ok);
		int steps;
		steps = 0;
		@(negedge Clock);
		while (dtack_L && steps < WaitLimit) begin
			@(negedge Clock);
			steps++;
		end
		ok = !dtack_L;
	endtask

	task automatic busCycle(input addressT address, input logic write, input wordT data,
		input logic [1:0] strobes, output logic ok);
		@(posedge Clock);
		cpuRequest.address   <= address;
		cpuRequest.writeData <= data;
		cpuRequest.uds_L     <= strobes[1];
		cpuRequest.lds_L     <= strobes[0];
		cpuRequest.we_L      <= !write;
		cpuRequest.as_L      <= 1'b0;
		waitForAck(ok);
		@(posedge Clock);
		cpuRequest.as_L <= 1'b1;                   // the cycle ends once dtack_L was seen
		cpuRequest.we_L <= 1'b1;
	endtask

	initial begin : stimulus
		logic [31:0] randomValue;
		addressT     address;
		logic [1:0]  strobes;
		logic        ok;
		logic        timedOut;
		int          steps;
		timedOut   = 1'b0;
		cpuRequest = '{address: '0, writeData: '0, uds_L: 1'b1, lds_L: 1'b1, we_L: 1'b1,
			as_L: 1'b1, dramSelect: 1'b1};
		repeat (10) @(posedge Clock);
		Reset_L <= 1'b1;
		for (int n = 0; n < TransactionCount; n++) begin
			randomValue = $random(seed);
			address = {pickTag(randomValue[1:0] % 3), (randomValue[2] ? 3'd5 : 3'd2),
				randomValue[5:3], 1'b0};
			strobes = (randomValue[9:8] == 2'd1) ? 2'b01 : (randomValue[9:8] == 2'd2) ? 2'b10 : 2'b00;
			busCycle(address, randomValue[7:6] == 2'd0, randomValue[31:16], strobes, ok);
			if (!ok) begin
				$display("timeout: no dtack_L for the bus cycle at %h", address);
				timedOut = 1'b1;
				break;
			end
			repeat (1 + randomValue[11:10]) @(posedge Clock);
		end
		if (!timedOut) begin
			reportNow <= 1'b1;
			steps = 0;
			while (!reported && steps < WaitLimit) begin
				@(negedge Clock);
				steps++;
			end
			if (!reported) $display("timeout: the checker never printed its counts");
		end
		if (!timedOut && reported && errorCount == 0 && i_dut.i_properties.failCount == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- cacheController.f
source/cachePkg.sv
source/sweepCounter.sv
source/plruStore.sv
source/tagStore.sv
source/lineStore.sv
source/cacheSequencer.sv
source/cacheController.sv
test/cacheController_properties.sv
test/cacheChecker.sv
test/cacheControllerTb.sv
